// ==== build.f ====
logic/rvwb_pkg.sv
logic/ex_mem_regs.sv
logic/data_mem.sv
logic/mem_wb_regs.sv
logic/wb_stage.sv
logic/reg_file.sv
logic/rvwb_top.sv
dv/tb_clk_gen.sv
dv/rvwb_tb.sv

// ==== dv/rvwb_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvwb_tb import rvwb_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int TEST_CYCLES  = 2000;                 // Rough length of all tests.
    localparam int MAX_CYCLES   = TEST_CYCLES * 3 / 2;

    // Expected writeback of one issued instruction.
    typedef struct packed {
        logic                  wen;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       data;
        logic                  ebreak;
    } wb_exp_t;

    logic                  clk;
    logic                  rst_n;
    logic                  ex_wen_i;
    logic [REG_ADDR_W-1:0] ex_waddr_i;
    logic [XLEN-1:0]       ex_alu_res_i;
    logic [XLEN-1:0]       ex_store_data_i;
    logic                  ex_mem_ren_i;
    logic                  ex_mem_wen_i;
    logic [SIZE_W-1:0]     ex_size_i;
    logic                  ex_unsigned_i;
    logic                  ex_ebreak_i;
    logic [REG_ADDR_W-1:0] dbg_raddr_i;
    logic                  wb_wen_o;
    logic [REG_ADDR_W-1:0] wb_waddr_o;
    logic [XLEN-1:0]       wb_wdata_o;
    logic                  halted_o;
    logic [XLEN-1:0]       dbg_rdata_o;

    wb_exp_t               pipe [$];              // Instructions on their way to writeback.
    logic [7:0]            smem [MEM_WORDS*8];    // Byte image of the data memory.
    logic [XLEN-1:0]       sreg [NUM_REGS];
    logic                  m_halted;
    logic                  store_block;
    logic [REG_ADDR_W-1:0] dbg_next;
    logic [REG_ADDR_W-1:0] dbg_cur;
    int                    errs;
    int                    test_errs;
    int                    tests;
    int                    cycles;

    tb_clk_gen u_clk_gen (
        .clk_o (clk)
    );

    rvwb_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .ex_wen_i        (ex_wen_i),
        .ex_waddr_i      (ex_waddr_i),
        .ex_alu_res_i    (ex_alu_res_i),
        .ex_store_data_i (ex_store_data_i),
        .ex_mem_ren_i    (ex_mem_ren_i),
        .ex_mem_wen_i    (ex_mem_wen_i),
        .ex_size_i       (ex_size_i),
        .ex_unsigned_i   (ex_unsigned_i),
        .ex_ebreak_i     (ex_ebreak_i),
        .dbg_raddr_i     (dbg_raddr_i),
        .wb_wen_o        (wb_wen_o),
        .wb_waddr_o      (wb_waddr_o),
        .wb_wdata_o      (wb_wdata_o),
        .halted_o        (halted_o),
        .dbg_rdata_o     (dbg_rdata_o)
    );

    function automatic logic [XLEN-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // Random upper bits, a word index and an offset aligned to the size.
    function automatic logic [XLEN-1:0] mem_addr(input logic [4:0] word,
                                                 input logic [SIZE_W-1:0] size);
        logic [XLEN-1:0] hi;
        logic [31:0]     r;
        hi = rand64();
        r  = $urandom;
        return {hi[63:11], 3'b000, word, r[2:0] & (3'b111 << size)};
    endfunction

    function automatic logic [XLEN-1:0] model_load(input logic [XLEN-1:0] addr,
                                                   input logic [SIZE_W-1:0] size,
                                                   input logic uns);
        logic [XLEN-1:0] val;
        logic [10:0]     idx;
        int              nbytes;
        val    = '0;
        nbytes = 1 << size;
        for (int i = 0; i < nbytes; i++) begin
            idx = addr[10:0] + 11'(i);
            val = val | (64'(smem[idx]) << (8 * i));   // Little endian.
        end
        // Signed loads copy the top loaded bit upward.
        if (!uns && nbytes < 8 && ((val >> (8 * nbytes - 1)) & 64'd1) != 64'd0) begin
            val = val | ({XLEN{1'b1}} << (8 * nbytes));
        end
        return val;
    endfunction

    task automatic model_store(input logic [XLEN-1:0] addr, input logic [SIZE_W-1:0] size,
                               input logic [XLEN-1:0] data);
        logic [10:0] idx;
        int          nbytes;
        nbytes = 1 << size;
        for (int i = 0; i < nbytes; i++) begin
            idx       = addr[10:0] + 11'(i);
            smem[idx] = 8'(data >> (8 * i));
        end
    endtask

    task automatic value_error(input string name, input logic [XLEN-1:0] expv,
                               input logic [XLEN-1:0] gotv);
        errs++;
        test_errs++;
        $display("FAILED t=%0t %s expected 0x%h got 0x%h", $time, name, expv, gotv);
    endtask

    // Runs at the falling edge, where all outputs are settled.
    task automatic check_cycle();
        wb_exp_t e;
        logic    exp_wen;
        if (dbg_rdata_o !== sreg[dbg_cur]) begin
            value_error("dbg_rdata_o", sreg[dbg_cur], dbg_rdata_o);
        end
        if (halted_o !== m_halted) begin
            value_error("halted_o", 64'(m_halted), 64'(halted_o));
        end
        if (pipe.size() == 3) begin
            e       = pipe.pop_back();
            exp_wen = e.wen && !m_halted;   // No writes once halted.
            if (wb_wen_o !== exp_wen) begin
                value_error("wb_wen_o", 64'(exp_wen), 64'(wb_wen_o));
            end
            if (wb_waddr_o !== e.waddr) begin
                value_error("wb_waddr_o", 64'(e.waddr), 64'(wb_waddr_o));
            end
            if (wb_wdata_o !== e.data) begin
                value_error("wb_wdata_o", e.data, wb_wdata_o);
            end
            if (exp_wen && e.waddr != '0) begin
                sreg[e.waddr] = e.data;
            end
            dbg_next = e.waddr;             // Read back on the next cycle.
            if (e.ebreak) begin
                m_halted = 1'b1;
            end
        end
    endtask

    task automatic run_op(input logic wen, input logic [REG_ADDR_W-1:0] waddr,
                          input logic [XLEN-1:0] alu, input logic [XLEN-1:0] sdata,
                          input logic ren, input logic mwen, input logic [SIZE_W-1:0] size,
                          input logic uns, input logic ebrk);
        wb_exp_t e;
        @(posedge clk);
        ex_wen_i        <= wen;
        ex_waddr_i      <= waddr;
        ex_alu_res_i    <= alu;
        ex_store_data_i <= sdata;
        ex_mem_ren_i    <= ren;
        ex_mem_wen_i    <= mwen;
        ex_size_i       <= size;
        ex_unsigned_i   <= uns;
        ex_ebreak_i     <= ebrk;
        dbg_raddr_i     <= dbg_next;
        dbg_cur          = dbg_next;
        e.wen    = wen;
        e.waddr  = waddr;
        e.ebreak = ebrk;
        e.data   = ren ? model_load(alu, size, uns) : alu;
        if (mwen && !store_block) begin
            model_store(alu, size, sdata);
        end
        pipe.push_front(e);
        @(negedge clk);
        check_cycle();
    endtask

    task automatic idle_op(input logic [REG_ADDR_W-1:0] waddr);
        run_op(1'b0, waddr, '0, '0, 1'b0, 1'b0, SIZE_B, 1'b0, 1'b0);
    endtask

    task automatic end_test(input string name);
        logic [31:0] r;
        for (int i = 0; i < 3; i++) begin   // Drain the pipeline.
            r = $urandom;
            idle_op(r[4:0]);
        end
        $display("test %s: done, %0d errors", name, test_errs);
        tests++;
        test_errs = 0;
    endtask

    initial begin
        logic [31:0]       r;
        logic [XLEN-1:0]   a;
        logic [SIZE_W-1:0] sz;
        void'($urandom(32'hcc293ec7));
        rst_n           = 1'b0;
        ex_wen_i        = 1'b0;
        ex_waddr_i      = '0;
        ex_alu_res_i    = '0;
        ex_store_data_i = '0;
        ex_mem_ren_i    = 1'b0;
        ex_mem_wen_i    = 1'b0;
        ex_size_i       = SIZE_B;
        ex_unsigned_i   = 1'b0;
        ex_ebreak_i     = 1'b0;
        dbg_raddr_i     = '0;
        m_halted        = 1'b0;
        store_block     = 1'b0;
        dbg_next        = '0;
        dbg_cur         = '0;
        errs            = 0;
        test_errs       = 0;
        tests           = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            sreg[i] = '0;
        end

        // Reset state.
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            r = $urandom;
            dbg_raddr_i <= r[4:0];
            dbg_cur      = r[4:0];
            @(negedge clk);
            if (wb_wen_o !== 1'b0) begin
                value_error("wb_wen_o", 64'd0, 64'(wb_wen_o));
            end
            check_cycle();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_cycle();
        for (int i = 0; i < 4; i++) begin
            r = $urandom;
            idle_op(r[4:0]);
        end
        end_test("reset state");

        for (int i = 0; i < 300; i++) begin
            r = $urandom;
            run_op(r[0] | r[1], r[6:2], rand64(), rand64(), 1'b0, 1'b0, r[8:7], r[9], 1'b0);
        end
        end_test("alu writeback");

        // Clear the model's words with double stores first.
        for (int i = 0; i < 32; i++) begin
            run_op(1'b0, 5'd0, mem_addr(5'(i), SIZE_D), '0, 1'b0, 1'b1, SIZE_D, 1'b0, 1'b0);
        end
        for (int i = 0; i < 400; i++) begin
            r  = $urandom;
            sz = r[2:1];
            a  = mem_addr(r[7:3], sz);
            if (r[0]) begin
                run_op(1'b0, r[12:8], a, rand64(), 1'b0, 1'b1, sz, 1'b0, 1'b0);
            end else begin
                run_op(1'b1, r[12:8], a, '0, 1'b1, 1'b0, sz, r[13], 1'b0);
            end
        end
        end_test("stores and loads");

        for (int i = 0; i < 40; i++) begin
            r = $urandom;
            run_op(1'b1, r[0] ? 5'd0 : r[5:1], rand64(), '0, 1'b0, 1'b0, SIZE_D, 1'b0, 1'b0);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            idle_op(5'(i));                     // Sweep the debug port.
        end
        end_test("register file");

        r = $urandom;
        run_op(1'b1, r[4:0] | 5'd1, rand64(), '0, 1'b0, 1'b0, SIZE_D, 1'b0, 1'b1);
        for (int i = 0; i < 3; i++) begin
            idle_op(5'd0);
        end
        store_block = 1'b1;
        if (halted_o !== 1'b1) begin
            errs++;
            test_errs++;
            $display("halted_o did not rise after the ebreak reached writeback");
        end
        for (int i = 0; i < 100; i++) begin
            r  = $urandom;
            sz = r[3:2];
            a  = mem_addr(r[8:4], sz);
            case (r[1:0])
                2'd2:    run_op(1'b0, r[13:9], a, rand64(), 1'b0, 1'b1, sz, 1'b0, 1'b0);
                2'd3:    run_op(1'b1, r[13:9], a, '0, 1'b1, 1'b0, sz, r[14], 1'b0);
                default: run_op(1'b1, r[13:9], rand64(), '0, 1'b0, 1'b0, SIZE_D, 1'b0, 1'b0);
            endcase
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            idle_op(5'(i));
        end
        end_test("halt");

        $display("tests run: %0d, errors: %0d", tests, errs);
        if (errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Ends a run that stops making progress.
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);

    localparam int HALF_PERIOD = 50;   // 100 ns clock.

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_mem import rvwb_pkg::*; (
    input  wire logic                             clk,
    input  wire logic                             mem_ren_i,
    input  wire logic                             mem_wen_i,
    input  wire logic                             halted_i,
    input  wire logic [MEM_ADDR_W+BYTE_OFF_W-1:0] addr_i,
    input  wire logic [SIZE_W-1:0]                size_i,
    input  wire logic [XLEN-1:0]                  store_data_i,
    output logic [XLEN-1:0]                       rdata_o
);

    logic [XLEN-1:0]       mem [MEM_WORDS];
    logic [MEM_ADDR_W-1:0] word_idx;
    logic [BYTE_OFF_W-1:0] byte_off;
    mem_word_u             wdata_u;
    mem_word_u             wmask_u;
    logic                  store_en;

    assign word_idx = addr_i[MEM_ADDR_W+BYTE_OFF_W-1:BYTE_OFF_W];
    assign byte_off = addr_i[BYTE_OFF_W-1:0];
    assign store_en = mem_wen_i && !halted_i;   // A halted core stores nothing.

    // Move the low bytes of the store data into their lane.
    always_comb begin
        wdata_u = '0;
        wmask_u = '0;
        case (size_i)
            SIZE_B: begin
                wdata_u.bytes[byte_off] = store_data_i[7:0];
                wmask_u.bytes[byte_off] = '1;
            end
            SIZE_H: begin
                wdata_u.halves[byte_off[2:1]] = store_data_i[15:0];
                wmask_u.halves[byte_off[2:1]] = '1;
            end
            SIZE_W32: begin
                wdata_u.words[byte_off[2]] = store_data_i[31:0];
                wmask_u.words[byte_off[2]] = '1;
            end
            default: begin
                wdata_u.dword = store_data_i;
                wmask_u.dword = '1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            // Bytes outside the mask keep their old value.
            mem[word_idx] <= (mem[word_idx] & ~wmask_u.dword) | (wdata_u.dword & wmask_u.dword);
        end
        if (mem_ren_i) begin
            rdata_o <= mem[word_idx];   // Whole word, lane picked in writeback.
        end
    end

endmodule

`default_nettype wire

// ==== logic/ex_mem_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_mem_regs import rvwb_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  wen_i,
    input  wire logic [REG_ADDR_W-1:0] waddr_i,
    input  wire logic [XLEN-1:0]       alu_res_i,
    input  wire logic [XLEN-1:0]       store_data_i,
    input  wire logic                  mem_ren_i,
    input  wire logic                  mem_wen_i,
    input  wire logic [SIZE_W-1:0]     size_i,
    input  wire logic                  unsigned_i,
    input  wire logic                  ebreak_i,
    output logic                       wen_o,
    output logic [REG_ADDR_W-1:0]      waddr_o,
    output logic [XLEN-1:0]            alu_res_o,
    output logic [XLEN-1:0]            store_data_o,
    output logic                       mem_ren_o,
    output logic                       mem_wen_o,
    output logic [SIZE_W-1:0]          size_o,
    output logic                       unsigned_o,
    output logic                       ebreak_o
);

    // Control fields. Strobes come out of reset idle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wen_o      <= 1'b0;
            waddr_o    <= '0;
            mem_ren_o  <= 1'b0;
            mem_wen_o  <= 1'b0;
            size_o     <= SIZE_B;
            unsigned_o <= 1'b0;
            ebreak_o   <= 1'b0;
        end else begin
            wen_o      <= wen_i;
            waddr_o    <= waddr_i;
            mem_ren_o  <= mem_ren_i;
            mem_wen_o  <= mem_wen_i;
            size_o     <= size_i;
            unsigned_o <= unsigned_i;
            ebreak_o   <= ebreak_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_res_o    <= alu_res_i;     // Also the memory address.
        store_data_o <= store_data_i;
    end

endmodule

`default_nettype wire

// ==== logic/mem_wb_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_wb_regs import rvwb_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  reg_wen_i,     // Register write enable.
    input  wire logic [REG_ADDR_W-1:0] reg_waddr_i,   // Register write address.
    input  wire logic [XLEN-1:0]       alu_res_i,
    input  wire logic                  load_i,
    input  wire logic [SIZE_W-1:0]     size_i,
    input  wire logic                  unsigned_i,
    input  wire logic                  ebreak_i,
    output logic                       reg_wen_o,
    output logic [REG_ADDR_W-1:0]      reg_waddr_o,
    output logic [XLEN-1:0]            alu_res_o,
    output logic                       load_o,
    output logic [SIZE_W-1:0]          size_o,
    output logic                       unsigned_o,
    output logic                       ebreak_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wen_o   <= 1'b0;
            reg_waddr_o <= '0;
            load_o      <= 1'b0;
            size_o      <= SIZE_B;
            unsigned_o  <= 1'b0;
            ebreak_o    <= 1'b0;
        end else begin
            reg_wen_o   <= reg_wen_i;
            reg_waddr_o <= reg_waddr_i;
            load_o      <= load_i;
            size_o      <= size_i;
            unsigned_o  <= unsigned_i;
            ebreak_o    <= ebreak_i;
        end
    end

    // The ALU result travels beside the load word from data_mem.
    // Its low bits select the load lane in writeback.
    always_ff @(posedge clk) begin
        alu_res_o <= alu_res_i;
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file import rvwb_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  wen_i,
    input  wire logic [REG_ADDR_W-1:0] waddr_i,
    input  wire logic [XLEN-1:0]       wdata_i,
    input  wire logic [REG_ADDR_W-1:0] raddr_i,
    output logic [XLEN-1:0]            rdata_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin   // x0 is never written.
            regs[waddr_i] <= wdata_i;
        end
    end

    // Debug read port.
    assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

`default_nettype wire

// ==== logic/rvwb_pkg.sv ====
`default_nettype none

package rvwb_pkg;

    // Datapath and register file.
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Data memory geometry.
    localparam int MEM_ADDR_W = 8;    // Index of a 64-bit word.
    localparam int MEM_WORDS  = 256;
    localparam int BYTE_OFF_W = 3;    // Byte offset inside a word.

    // Access size codes, as in funct3[1:0].
    localparam int SIZE_W = 2;
    localparam logic [SIZE_W-1:0] SIZE_B   = 2'd0;
    localparam logic [SIZE_W-1:0] SIZE_H   = 2'd1;
    localparam logic [SIZE_W-1:0] SIZE_W32 = 2'd2;
    localparam logic [SIZE_W-1:0] SIZE_D   = 2'd3;

    // One memory word, seen per lane or as a whole.
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
        logic [XLEN-1:0]  dword;
    } mem_word_u;

endpackage

`default_nettype wire

// ==== logic/rvwb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvwb_top import rvwb_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  ex_wen_i,
    input  wire logic [REG_ADDR_W-1:0] ex_waddr_i,
    input  wire logic [XLEN-1:0]       ex_alu_res_i,
    input  wire logic [XLEN-1:0]       ex_store_data_i,
    input  wire logic                  ex_mem_ren_i,
    input  wire logic                  ex_mem_wen_i,
    input  wire logic [SIZE_W-1:0]     ex_size_i,
    input  wire logic                  ex_unsigned_i,
    input  wire logic                  ex_ebreak_i,
    input  wire logic [REG_ADDR_W-1:0] dbg_raddr_i,
    output logic                       wb_wen_o,
    output logic [REG_ADDR_W-1:0]      wb_waddr_o,
    output logic [XLEN-1:0]            wb_wdata_o,
    output logic                       halted_o,
    output logic [XLEN-1:0]            dbg_rdata_o
);

    // EX/MEM outputs.
    logic                  exm_wen;
    logic [REG_ADDR_W-1:0] exm_waddr;
    logic [XLEN-1:0]       exm_alu_res;
    logic [XLEN-1:0]       exm_store_data;
    logic                  exm_mem_ren;
    logic                  exm_mem_wen;
    logic [SIZE_W-1:0]     exm_size;
    logic                  exm_unsigned;
    logic                  exm_ebreak;

    // MEM/WB outputs.
    logic                  mwb_wen;
    logic [REG_ADDR_W-1:0] mwb_waddr;
    logic [XLEN-1:0]       mwb_alu_res;
    logic                  mwb_load;
    logic [SIZE_W-1:0]     mwb_size;
    logic                  mwb_unsigned;
    logic                  mwb_ebreak;
    logic [XLEN-1:0]       mem_rdata;

    ex_mem_regs u_ex_mem_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .wen_i        (ex_wen_i),
        .waddr_i      (ex_waddr_i),
        .alu_res_i    (ex_alu_res_i),
        .store_data_i (ex_store_data_i),
        .mem_ren_i    (ex_mem_ren_i),
        .mem_wen_i    (ex_mem_wen_i),
        .size_i       (ex_size_i),
        .unsigned_i   (ex_unsigned_i),
        .ebreak_i     (ex_ebreak_i),
        .wen_o        (exm_wen),
        .waddr_o      (exm_waddr),
        .alu_res_o    (exm_alu_res),
        .store_data_o (exm_store_data),
        .mem_ren_o    (exm_mem_ren),
        .mem_wen_o    (exm_mem_wen),
        .size_o       (exm_size),
        .unsigned_o   (exm_unsigned),
        .ebreak_o     (exm_ebreak)
    );

    data_mem u_data_mem (
        .clk          (clk),
        .mem_ren_i    (exm_mem_ren),
        .mem_wen_i    (exm_mem_wen),
        .halted_i     (halted_o),
        .addr_i       (exm_alu_res[MEM_ADDR_W+BYTE_OFF_W-1:0]),
        .size_i       (exm_size),
        .store_data_i (exm_store_data),
        .rdata_o      (mem_rdata)
    );

    // Captured on the same edge as the memory read word.
    mem_wb_regs u_mem_wb_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wen_i   (exm_wen),
        .reg_waddr_i (exm_waddr),
        .alu_res_i   (exm_alu_res),
        .load_i      (exm_mem_ren),
        .size_i      (exm_size),
        .unsigned_i  (exm_unsigned),
        .ebreak_i    (exm_ebreak),
        .reg_wen_o   (mwb_wen),
        .reg_waddr_o (mwb_waddr),
        .alu_res_o   (mwb_alu_res),
        .load_o      (mwb_load),
        .size_o      (mwb_size),
        .unsigned_o  (mwb_unsigned),
        .ebreak_o    (mwb_ebreak)
    );

    wb_stage u_wb_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wen_i   (mwb_wen),
        .reg_waddr_i (mwb_waddr),
        .alu_res_i   (mwb_alu_res),
        .load_i      (mwb_load),
        .size_i      (mwb_size),
        .unsigned_i  (mwb_unsigned),
        .ebreak_i    (mwb_ebreak),
        .mem_rdata_i (mem_rdata),
        .wb_wen_o    (wb_wen_o),
        .wb_waddr_o  (wb_waddr_o),
        .wb_wdata_o  (wb_wdata_o),
        .halted_o    (halted_o)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wen_i   (wb_wen_o),
        .waddr_i (wb_waddr_o),
        .wdata_i (wb_wdata_o),
        .raddr_i (dbg_raddr_i),
        .rdata_o (dbg_rdata_o)
    );

endmodule

`default_nettype wire

// ==== logic/wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_stage import rvwb_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  reg_wen_i,
    input  wire logic [REG_ADDR_W-1:0] reg_waddr_i,
    input  wire logic [XLEN-1:0]       alu_res_i,
    input  wire logic                  load_i,
    input  wire logic [SIZE_W-1:0]     size_i,
    input  wire logic                  unsigned_i,
    input  wire logic                  ebreak_i,
    input  wire logic [XLEN-1:0]       mem_rdata_i,
    output logic                       wb_wen_o,
    output logic [REG_ADDR_W-1:0]      wb_waddr_o,
    output logic [XLEN-1:0]            wb_wdata_o,
    output logic                       halted_o
);

    mem_word_u             rd_u;
    logic [BYTE_OFF_W-1:0] byte_off;
    logic                  sext;
    logic [XLEN-1:0]       load_val;

    assign rd_u     = mem_rdata_i;
    assign byte_off = alu_res_i[BYTE_OFF_W-1:0];
    assign sext     = !unsigned_i;

    // Pick the lane and extend it to XLEN.
    always_comb begin
        case (size_i)
            SIZE_B: begin
                load_val = {{(XLEN-8){sext & rd_u.bytes[byte_off][7]}},
                            rd_u.bytes[byte_off]};
            end
            SIZE_H: begin
                load_val = {{(XLEN-16){sext & rd_u.halves[byte_off[2:1]][15]}},
                            rd_u.halves[byte_off[2:1]]};
            end
            SIZE_W32: begin
                load_val = {{(XLEN-32){sext & rd_u.words[byte_off[2]][31]}},
                            rd_u.words[byte_off[2]]};
            end
            default: load_val = rd_u.dword;
        endcase
    end

    assign wb_wdata_o = load_i ? load_val : alu_res_i;
    assign wb_waddr_o = reg_waddr_i;
    assign wb_wen_o   = reg_wen_i && !halted_o;   // The ebreak itself still writes.

    // Sticky until reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted_o <= 1'b0;
        end else if (ebreak_i) begin
            halted_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f build.f --top-module rvwb_tb -o rvwb_sim
if [ $? -ne 0 ]; then
    echo "run.sh: compile failed"
    exit 1
fi

./obj_dir/rvwb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

# The run passes only if the log holds the pass line.
if grep -qx "NO ERRORS" sim.log; then
    echo "run.sh: pass"
    exit 0
else
    echo "run.sh: fail"
    exit 1
fi
